/* design/soc_pkg.sv */
// system-level types and address map constants for the processor command port
package soc_pkg;

    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2
    } cmd_op_e;

    // one command from the processor side, held by the source while busy
    typedef struct packed {
        cmd_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cmd_t;

    // address bit 29 set selects device space, clear selects data memory
    localparam int DEV_SPACE_BIT = 29;

    // device lane selects ride on addr[17:16]
    localparam int DEV_SEL_LSB = 16;

    localparam int WORD_LSB = 2;    // byte offset inside a word

endpackage

/* design/wb_data_ram.sv */
// data memory slave: word-wide storage, one-cycle ack with a parity tag on the returned word
`timescale 1ns/1ps

module wb_data_ram #(
    parameter int MEM_WORDS = 256
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  wb_pkg::wb_req_t req_i,
    output wb_pkg::wb_rsp_t rsp_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0]      mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             hit;
    logic             ack_q;
    logic [31:0]      rd_q;

    // word index from the low address bits, lanes ignored
    assign idx = req_i.addr[soc_pkg::WORD_LSB +: IDX_W];
    assign hit = req_i.cyc && req_i.stb;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= hit;   // stb lasts one cycle so ack does too
        end
    end

    always_ff @(posedge clk_i) begin
        if (hit) begin
            if (req_i.we) begin
                mem[idx] <= req_i.data; // full word always
            end
            rd_q <= mem[idx];
        end
    end

    always_comb begin
        rsp_o.ack  = ack_q;
        rsp_o.data = rd_q;
        rsp_o.tgd  = ^rd_q;
    end

endmodule

/* design/wb_decoder.sv */
// address decoder: steers each bus cycle to data memory or devices and muxes the answer back
`timescale 1ns/1ps

module wb_decoder (
    input  wb_pkg::wb_req_t req_i,
    output wb_pkg::wb_req_t mem_req_o,
    output wb_pkg::wb_req_t dev_req_o,
    input  wb_pkg::wb_rsp_t mem_rsp_i,
    input  wb_pkg::wb_rsp_t dev_rsp_i,
    output wb_pkg::wb_rsp_t rsp_o
);

    logic dev_hit;

    // address is held by the master for the whole cycle, so the select is stable until ack
    assign dev_hit = req_i.addr[soc_pkg::DEV_SPACE_BIT];

    always_comb begin
        mem_req_o     = req_i;
        mem_req_o.cyc = req_i.cyc & ~dev_hit;
        mem_req_o.stb = req_i.stb & ~dev_hit;

        dev_req_o     = req_i;
        dev_req_o.cyc = req_i.cyc & dev_hit;
        dev_req_o.stb = req_i.stb & dev_hit;
    end

    // only the addressed slave gets through
    always_comb begin
        if (dev_hit) begin
            rsp_o = dev_rsp_i;
        end else begin
            rsp_o = mem_rsp_i;
        end
    end

endmodule

/* design/wb_dev_regs.sv */
// device register bank slave with half-word write lanes and a parity fault-injection bit
`timescale 1ns/1ps

module wb_dev_regs #(
    parameter int DEV_REGS = 4
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  wb_pkg::wb_req_t req_i,
    output wb_pkg::wb_rsp_t rsp_o
);

    localparam int IDX_W = $clog2(DEV_REGS);

    logic [31:0]      regs [DEV_REGS];
    logic [IDX_W-1:0] idx;
    logic             hit;
    logic             fault_en;
    logic             ack_q;
    logic             inv_q;
    logic [31:0]      rd_q;

    assign idx      = req_i.addr[soc_pkg::WORD_LSB +: IDX_W];
    assign hit      = req_i.cyc && req_i.stb;
    assign fault_en = regs[DEV_REGS-1][0];  // bit 0 of the last register

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < DEV_REGS; i++) begin
                regs[i] <= '0;
            end
            ack_q <= 1'b0;
            inv_q <= 1'b0;
        end else begin
            ack_q <= hit;
            if (hit) begin
                inv_q <= !req_i.we && fault_en; // corrupt read tags only
                if (req_i.we && req_i.sel[0]) begin
                    regs[idx][15:0] <= req_i.data[15:0];
                end
                if (req_i.we && req_i.sel[1]) begin
                    regs[idx][31:16] <= req_i.data[31:16];
                end
            end
        end
    end

    // returns the word as it was before a write at the same edge
    always_ff @(posedge clk_i) begin
        if (hit) begin
            rd_q <= regs[idx];
        end
    end

    always_comb begin
        rsp_o.ack  = ack_q;
        rsp_o.data = rd_q;
        rsp_o.tgd  = (^rd_q) ^ inv_q;
    end

endmodule

/* design/wb_master.sv */
// bus master: turns processor read/write commands into single bus cycles with a parity check
`timescale 1ns/1ps

module wb_master (
    input  logic            clk_i,
    input  logic            rst_i,
    input  soc_pkg::cmd_t   cmd_i,
    output logic            busy_o,
    output logic [31:0]     rdata_o,
    output logic            rdata_valid_o,
    output logic            err_o,
    output wb_pkg::wb_req_t bus_req_o,
    input  wb_pkg::wb_rsp_t bus_rsp_i
);

    wb_pkg::master_state_e state_q;
    logic                  cyc_q;
    logic                  stb_q;

    // latched request
    logic                  we_q;
    logic [1:0]            sel_q;
    logic [31:0]           addr_q;
    logic [31:0]           data_q;
    logic                  tgd_q;

    logic                  accept;
    logic                  parity_ok;
    logic                  done;

    assign accept    = (state_q == wb_pkg::IDLE) && (cmd_i.op != soc_pkg::CMD_NONE);
    assign parity_ok = (bus_rsp_i.tgd == ^bus_rsp_i.data);
    assign done      = (state_q == wb_pkg::WAIT_ACK) && bus_rsp_i.ack;
    assign busy_o    = (state_q != wb_pkg::IDLE);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q       <= wb_pkg::IDLE;
            cyc_q         <= 1'b0;
            stb_q         <= 1'b0;
            rdata_valid_o <= 1'b0;
            err_o         <= 1'b0;
        end else begin
            rdata_valid_o <= 1'b0;  // both are single-cycle pulses
            err_o         <= 1'b0;
            case (state_q)
                wb_pkg::IDLE: begin
                    if (accept) begin
                        state_q <= wb_pkg::STROBE;
                    end
                end
                wb_pkg::STROBE: begin
                    cyc_q   <= 1'b1;
                    stb_q   <= 1'b1;
                    state_q <= wb_pkg::WAIT_ACK;
                end
                wb_pkg::WAIT_ACK: begin
                    stb_q <= 1'b0;
                    if (bus_rsp_i.ack) begin
                        cyc_q         <= 1'b0;
                        state_q       <= wb_pkg::IDLE;
                        err_o         <= !parity_ok;    // ends the cycle, no hang
                        rdata_valid_o <= parity_ok && !we_q;
                    end
                end
                default: state_q <= wb_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= cmd_i.addr;
            data_q <= cmd_i.wdata;
            tgd_q  <= ^cmd_i.wdata;
            we_q   <= (cmd_i.op == soc_pkg::CMD_WRITE);
            // device space uses the lanes from the address, memory always full word
            sel_q  <= cmd_i.addr[soc_pkg::DEV_SPACE_BIT] ?
                      cmd_i.addr[soc_pkg::DEV_SEL_LSB +: 2] : 2'b11;
        end
        if (done && parity_ok && !we_q) begin
            rdata_o <= bus_rsp_i.data;
        end
    end

    always_comb begin
        bus_req_o.cyc  = cyc_q;
        bus_req_o.stb  = stb_q;
        bus_req_o.we   = we_q;
        bus_req_o.sel  = sel_q;
        bus_req_o.addr = addr_q;
        bus_req_o.data = data_q;
        bus_req_o.tgd  = tgd_q;
    end

endmodule

/* design/wb_pkg.sv */
// bus-level types shared by the master, the decoder and the slaves of the data bus
package wb_pkg;

    // master to slave, 70 bits
    typedef struct packed {
        logic        cyc;   // bus cycle in progress
        logic        stb;   // one-cycle strobe at cycle start
        logic        we;
        logic [1:0]  sel;   // half-word lanes, [1] upper
        logic [31:0] addr;
        logic [31:0] data;
        logic        tgd;   // even parity of data
    } wb_req_t;

    // slave to master, 34 bits
    typedef struct packed {
        logic        ack;
        logic [31:0] data;
        logic        tgd;   // parity of data as seen by the slave
    } wb_rsp_t;

    // master FSM
    // STROBE puts cyc and stb on the bus at its closing edge
    // WAIT_ACK drops stb and holds cyc until the slave answers
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        STROBE   = 2'd1,
        WAIT_ACK = 2'd2
    } master_state_e;

endpackage

/* design/wb_subsystem_top.sv */
// data-bus subsystem top: command port, master, address decoder, data memory and device registers
`timescale 1ns/1ps

module wb_subsystem_top #(
    parameter int MEM_WORDS = 256,
    parameter int DEV_REGS  = 4
) (
    input  logic          clk_i,
    input  logic          rst_i,
    input  soc_pkg::cmd_t cmd_i,
    output logic          busy_o,
    output logic [31:0]   rdata_o,
    output logic          rdata_valid_o,
    output logic          err_o
);

    wb_pkg::wb_req_t bus_req;
    wb_pkg::wb_rsp_t bus_rsp;
    wb_pkg::wb_req_t mem_req;
    wb_pkg::wb_rsp_t mem_rsp;
    wb_pkg::wb_req_t dev_req;
    wb_pkg::wb_rsp_t dev_rsp;

    wb_master i_master (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .cmd_i         (cmd_i),
        .busy_o        (busy_o),
        .rdata_o       (rdata_o),
        .rdata_valid_o (rdata_valid_o),
        .err_o         (err_o),
        .bus_req_o     (bus_req),
        .bus_rsp_i     (bus_rsp)
    );

    wb_decoder i_decoder (
        .req_i     (bus_req),
        .mem_req_o (mem_req),
        .dev_req_o (dev_req),
        .mem_rsp_i (mem_rsp),
        .dev_rsp_i (dev_rsp),
        .rsp_o     (bus_rsp)
    );

    wb_data_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) i_data_ram (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (mem_req),
        .rsp_o (mem_rsp)
    );

    wb_dev_regs #(
        .DEV_REGS (DEV_REGS)
    ) i_dev_regs (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (dev_req),
        .rsp_o (dev_rsp)
    );

endmodule

/* list.f */
design/wb_pkg.sv
design/soc_pkg.sv
design/wb_master.sv
design/wb_decoder.sv
design/wb_data_ram.sv
design/wb_dev_regs.sv
design/wb_subsystem_top.sv
testbench/tb_wb_subsystem_sva.sv
testbench/tb_wb_subsystem.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_wb_subsystem -f list.f -o tb_sim \
    > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat build.log
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log 2>/dev/null && exit 0 || exit 1

/* testbench/tb_wb_subsystem.sv */
// testbench for the data-bus subsystem: drives commands, models memory and registers, checks results
`timescale 1ns/1ps

module tb_wb_subsystem;

    localparam int MEM_WORDS = 256;
    localparam int DEV_REGS  = 4;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);
    localparam int DEV_IDX_W = $clog2(DEV_REGS);
    localparam int LATENCY   = 3;   // accept edge to busy fall
    localparam int WAIT_MAX  = 20;

    typedef struct packed {
        logic        err;
        logic [31:0] word;
    } expect_t;

    logic              clk_i;
    logic              rst_i;
    soc_pkg::cmd_t     cmd_i;
    logic              busy_o;
    logic [31:0]       rdata_o;
    logic              rdata_valid_o;
    logic              err_o;

    logic [31:0]       model_mem  [MEM_WORDS];
    logic [31:0]       model_regs [DEV_REGS];
    logic [31:0]       addrs      [8];
    logic [1:0]        lane_pat   [4];
    expect_t           exp_res;
    soc_pkg::cmd_op_e  cur_op;
    int                checks;
    int                errors;
    int                tests;
    int                err_mark;

    wb_subsystem_top #(
        .MEM_WORDS (MEM_WORDS),
        .DEV_REGS  (DEV_REGS)
    ) i_dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .cmd_i         (cmd_i),
        .busy_o        (busy_o),
        .rdata_o       (rdata_o),
        .rdata_valid_o (rdata_valid_o),
        .err_o         (err_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // expected outcome of one command, updates the model state in acceptance order
    function automatic expect_t model_access(soc_pkg::cmd_t cmd);
        expect_t              res;
        logic [MEM_IDX_W-1:0] mi;
        logic [DEV_IDX_W-1:0] di;
        logic [1:0]           lanes;
        res   = '0;
        mi    = cmd.addr[soc_pkg::WORD_LSB +: MEM_IDX_W];
        di    = cmd.addr[soc_pkg::WORD_LSB +: DEV_IDX_W];
        lanes = cmd.addr[soc_pkg::DEV_SEL_LSB +: 2];
        if (cmd.addr[soc_pkg::DEV_SPACE_BIT]) begin
            if (cmd.op == soc_pkg::CMD_WRITE) begin
                if (lanes[0]) begin
                    model_regs[di][15:0] = cmd.wdata[15:0];
                end
                if (lanes[1]) begin
                    model_regs[di][31:16] = cmd.wdata[31:16];
                end
            end else begin
                res.word = model_regs[di];
                res.err  = model_regs[DEV_REGS-1][0];   // fault injection on
            end
        end else if (cmd.op == soc_pkg::CMD_WRITE) begin
            model_mem[mi] = cmd.wdata;  // lanes ignored by memory
        end else begin
            res.word = model_mem[mi];
        end
        return res;
    endfunction

    function automatic soc_pkg::cmd_t make_cmd(soc_pkg::cmd_op_e op, logic [31:0] addr,
                                               logic [31:0] wdata);
        soc_pkg::cmd_t c;
        c.op    = op;
        c.addr  = addr;
        c.wdata = wdata;
        return c;
    endfunction

    function automatic logic [31:0] dev_addr(int idx, logic [1:0] lanes);
        logic [31:0] a;
        a = '0;
        a[soc_pkg::DEV_SPACE_BIT]             = 1'b1;
        a[soc_pkg::DEV_SEL_LSB +: 2]          = lanes;
        a[soc_pkg::WORD_LSB +: DEV_IDX_W]     = idx[DEV_IDX_W-1:0];
        return a;
    endfunction

    task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // outcome packed as {err, valid}
    task automatic check_flag(string name, soc_pkg::cmd_op_e op, logic [1:0] exp,
                              logic [1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s (%s): expected %b, actual %b", name, op.name(), exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic abort(string why);
        $display("%s", why);
        $display("test failed");
        $finish;
    endtask

    // called at a falling edge with busy_o low, returns one cycle after acceptance
    task automatic issue(string name, soc_pkg::cmd_t cmd);
        cmd_i = cmd;
        @(negedge clk_i);
        if (busy_o !== 1'b1) begin
            abort($sformatf("command %s was not accepted while the DUT was idle", name));
        end
        exp_res  = model_access(cmd);
        cur_op   = cmd.op;
        err_mark = errors;
        cmd_i.op = soc_pkg::CMD_NONE;
    endtask

    task automatic finish(string name);
        int         cycles;
        int         early;
        logic [1:0] exp_flags;
        cycles = 0;
        early  = 0;
        while (busy_o === 1'b1) begin
            if (rdata_valid_o === 1'b1 || err_o === 1'b1) begin
                early++;
            end
            if (cycles == WAIT_MAX) begin
                abort($sformatf("timeout: busy_o stayed high during %s", name));
            end
            @(negedge clk_i);
            cycles++;
        end
        check_count({name, " latency"}, LATENCY, cycles);
        check_count({name, " early pulses"}, 0, early);
        if (cur_op == soc_pkg::CMD_READ) begin
            exp_flags = exp_res.err ? 2'b10 : 2'b01;
        end else begin
            exp_flags = 2'b00;  // writes end quietly
        end
        check_flag(name, cur_op, exp_flags, {err_o === 1'b1, rdata_valid_o === 1'b1});
        if (exp_flags == 2'b01) begin
            check_word(name, exp_res.word, rdata_o);
        end
        tests++;
        $display("%s: %0d mismatches", name, errors - err_mark);
    endtask

    task automatic run_cmd(string name, soc_pkg::cmd_op_e op, logic [31:0] addr,
                           logic [31:0] wdata);
        issue(name, make_cmd(op, addr, wdata));
        finish(name);
    endtask

    initial begin
        void'($urandom(678));
        rst_i    = 1'b0;
        cmd_i    = '0;
        checks   = 0;
        errors   = 0;
        tests    = 0;
        err_mark = 0;
        lane_pat = '{2'b01, 2'b10, 2'b11, 2'b00};
        for (int i = 0; i < DEV_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(negedge clk_i);
        rst_i = 1'b1;
        @(negedge clk_i);

        check_flag("reset pulses", soc_pkg::CMD_NONE, 2'b00, {err_o, rdata_valid_o});
        check_flag("reset busy", soc_pkg::CMD_NONE, 2'b00, {1'b0, busy_o});
        for (int i = 0; i < DEV_REGS; i++) begin
            run_cmd($sformatf("reset_reg%0d", i), soc_pkg::CMD_READ, dev_addr(i, 2'b11), '0);
        end

        // random memory traffic, bit 29 clear
        for (int i = 0; i < 8; i++) begin
            addrs[i] = $urandom;
            addrs[i][soc_pkg::DEV_SPACE_BIT] = 1'b0;
            run_cmd($sformatf("mem_wr%0d", i), soc_pkg::CMD_WRITE, addrs[i], $urandom);
        end
        for (int i = 0; i < 8; i++) begin
            run_cmd($sformatf("mem_rd%0d", i), soc_pkg::CMD_READ, addrs[i], '0);
        end

        // same register, so earlier lanes must survive later ones
        for (int i = 0; i < 4; i++) begin
            run_cmd($sformatf("lane_wr%0d", i), soc_pkg::CMD_WRITE,
                    dev_addr(1, lane_pat[i]), $urandom);
            run_cmd($sformatf("lane_rd%0d", i), soc_pkg::CMD_READ, dev_addr(1, 2'b11), '0);
        end

        // second command held during busy
        issue("hold_a", make_cmd(soc_pkg::CMD_WRITE, addrs[0], 32'h5a5a_0f0f));
        cmd_i = make_cmd(soc_pkg::CMD_READ, addrs[0], '0);
        finish("hold_a");
        issue("hold_b", cmd_i);
        finish("hold_b");

        run_cmd("fault_on", soc_pkg::CMD_WRITE, dev_addr(DEV_REGS-1, 2'b11), 32'h1);
        run_cmd("fault_dev_rd", soc_pkg::CMD_READ, dev_addr(1, 2'b11), '0);
        run_cmd("fault_mem_rd", soc_pkg::CMD_READ, addrs[1], '0);
        run_cmd("fault_off", soc_pkg::CMD_WRITE, dev_addr(DEV_REGS-1, 2'b01), 32'h0);
        run_cmd("clean_dev_rd", soc_pkg::CMD_READ, dev_addr(1, 2'b11), '0);
        run_cmd("clean_mem_rd", soc_pkg::CMD_READ, addrs[2], '0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* testbench/tb_wb_subsystem_sva.sv */
// bus protocol assertions for the master, bound into every wb_master instance
`timescale 1ns/1ps

module wb_master_sva (
    input logic                  clk_i,
    input logic                  rst_i,
    input logic                  busy_i,
    input wb_pkg::wb_req_t       bus_req_i,
    input wb_pkg::wb_rsp_t       bus_rsp_i
);

    // stb opens the cycle and lasts one cycle
    stb_at_start: assert property (@(posedge clk_i) disable iff (!rst_i)
        $rose(bus_req_i.cyc) |-> bus_req_i.stb)
        else $error("bus cycle started without stb");

    stb_single: assert property (@(posedge clk_i) disable iff (!rst_i)
        bus_req_i.stb |=> !bus_req_i.stb)
        else $error("stb held longer than one cycle");

    cyc_until_ack: assert property (@(posedge clk_i) disable iff (!rst_i)
        (bus_req_i.cyc && !bus_rsp_i.ack) |=> bus_req_i.cyc)
        else $error("cyc dropped before ack");

    ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_i)
        bus_rsp_i.ack |-> bus_req_i.cyc)
        else $error("ack without cyc");

    idle_after_reset: assert property (@(posedge clk_i)
        !rst_i |=> !busy_i)
        else $error("busy high after reset");

endmodule

bind wb_master wb_master_sva i_sva (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .busy_i    (busy_o),
    .bus_req_i (bus_req_o),
    .bus_rsp_i (bus_rsp_i)
);
